//--- core_pkg.sv
//========================================
// rename core shared definitions
//========================================
package core_pkg;

	localparam int NUM_AREGS = 32;	// architectural regs
	localparam int NUM_PREGS = 64;	// physical regs

	typedef logic [$clog2(NUM_AREGS)-1:0]	areg_idx_t;
	typedef logic [$clog2(NUM_PREGS)-1:0]	preg_idx_t;
	typedef logic [63:0]					word_t;
	typedef logic [31:0]					instr_t;	// op|dest|ra|rb|imm
	typedef logic [13:0]					imm_t;		// zero-extended on use
	typedef logic [2:0]						alu_op_t;

	localparam areg_idx_t ZERO_AREG = '0;	// always reads zero
	localparam preg_idx_t ZERO_PREG = '0;	// its fixed physical reg

	//========================================
	// opcodes, unlisted codes act as add
	//========================================
	localparam alu_op_t OP_ADD  = 3'd0;
	localparam alu_op_t OP_SUB  = 3'd1;
	localparam alu_op_t OP_AND  = 3'd2;
	localparam alu_op_t OP_OR   = 3'd3;
	localparam alu_op_t OP_XOR  = 3'd4;
	localparam alu_op_t OP_ADDI = 3'd5;	// ra + imm
	localparam alu_op_t OP_LUI  = 3'd6;	// imm << LUI_SHIFT

	localparam int LUI_SHIFT = 16;

	//========================================
	// reset mapping
	//========================================
	// areg i sits in preg i, the rest start out free
	localparam int        FREE_DEPTH = NUM_PREGS - NUM_AREGS;
	localparam preg_idx_t FREE_BASE  = preg_idx_t'(NUM_AREGS);

endpackage: core_pkg

//--- map_table.sv
//========================================
// rename map table
//========================================
module map_table (
	input  logic					clk,
	input  logic					reset_i,
	input  core_pkg::areg_idx_t		ra_i,
	input  core_pkg::areg_idx_t		rb_i,
	input  core_pkg::areg_idx_t		dest_i,
	input  logic					rename_en_i,	// fl pop, dest nonzero
	input  core_pkg::preg_idx_t		new_preg_i,
	input  logic					cdb_valid_i,
	input  core_pkg::preg_idx_t		cdb_tag_i,
	output core_pkg::preg_idx_t		opa_preg_o,
	output core_pkg::preg_idx_t		opb_preg_o,
	output logic					opa_rdy_o,
	output logic					opb_rdy_o,
	output core_pkg::preg_idx_t		old_preg_o
);
	import core_pkg::*;

	preg_idx_t				map_q [NUM_AREGS];	// areg -> preg
	logic [NUM_PREGS-1:0]	rdy_q;				// value present in prf

	assign opa_preg_o = map_q[ra_i];
	assign opb_preg_o = map_q[rb_i];
	assign opa_rdy_o  = rdy_q[opa_preg_o];
	assign opb_rdy_o  = rdy_q[opb_preg_o];
	assign old_preg_o = map_q[dest_i];	// read before this cycle's update

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_AREGS; i++) begin
				map_q[i] <= preg_idx_t'(i);	// identity map
			end
			rdy_q <= '1;	// all values zero and present
		end else begin
			if (cdb_valid_i) rdy_q[cdb_tag_i] <= 1'b1;	// wakeup
			if (rename_en_i) begin
				map_q[dest_i]     <= new_preg_i;
				rdy_q[new_preg_i] <= 1'b0;	// pending until broadcast
			end
		end
	end

	// core must never hand a fresh preg to areg zero
	a_no_zero_rename: assert property (@(posedge clk) disable iff (reset_i)
		rename_en_i |-> dest_i != ZERO_AREG);

endmodule: map_table

//--- free_list.sv
//========================================
// physical register free list
//========================================
module free_list (
	input  logic					clk,
	input  logic					reset_i,
	input  logic					pop_i,			// rename takes one
	input  logic					push_i,			// retire returns one
	input  core_pkg::preg_idx_t		push_preg_i,
	output logic					free_valid_o,
	output core_pkg::preg_idx_t		free_preg_o
);
	import core_pkg::*;

	localparam int PTR_W = $clog2(FREE_DEPTH);

	preg_idx_t			fifo_q [FREE_DEPTH];
	logic [PTR_W-1:0]	head_q;
	logic [PTR_W-1:0]	tail_q;
	logic [PTR_W:0]		count_q;

	assign free_valid_o = count_q != '0;
	assign free_preg_o  = fifo_q[head_q];	// next preg to hand out

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < FREE_DEPTH; i++) begin
				fifo_q[i] <= FREE_BASE + preg_idx_t'(i);	// pregs 32..63
			end
			head_q  <= '0;
			tail_q  <= '0;	// wrapped, queue starts full
			count_q <= (PTR_W+1)'(FREE_DEPTH);
		end else begin
			if (push_i) begin
				fifo_q[tail_q] <= push_preg_i;
				tail_q         <= tail_q + 1'b1;
			end
			if (pop_i) head_q <= head_q + 1'b1;
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: ;	// both or neither
			endcase
		end
	end

	// dispatch has to stall on an empty list
	a_no_pop_empty: assert property (@(posedge clk) disable iff (reset_i)
		pop_i |-> free_valid_o);

endmodule: free_list

//--- rs.sv
//========================================
// reservation station
//========================================
module rs #(
	parameter int RS_DEPTH  = 8,
	parameter int ROB_DEPTH = 16
) (
	input  logic							clk,
	input  logic							reset_i,
	input  logic							dispatch_i,
	input  core_pkg::alu_op_t				op_i,
	input  core_pkg::imm_t					imm_i,
	input  core_pkg::preg_idx_t				opa_preg_i,
	input  core_pkg::preg_idx_t				opb_preg_i,
	input  logic							opa_rdy_i,
	input  logic							opb_rdy_i,
	input  core_pkg::preg_idx_t				dest_preg_i,
	input  logic [$clog2(ROB_DEPTH)-1:0]	rob_idx_i,
	input  logic							cdb_valid_i,
	input  core_pkg::preg_idx_t				cdb_tag_i,
	output logic							full_o,
	output logic							iss_valid_o,
	output core_pkg::alu_op_t				iss_op_o,
	output core_pkg::imm_t					iss_imm_o,
	output core_pkg::preg_idx_t				iss_opa_o,
	output core_pkg::preg_idx_t				iss_opb_o,
	output core_pkg::preg_idx_t				iss_dest_o,
	output logic [$clog2(ROB_DEPTH)-1:0]	iss_rob_idx_o
);
	import core_pkg::*;

	localparam int ROB_W = $clog2(ROB_DEPTH);
	localparam int SEL_W = $clog2(RS_DEPTH);

	logic [RS_DEPTH-1:0]	valid_q;
	logic [RS_DEPTH-1:0]	rdya_q;		// opa tag broadcast seen
	logic [RS_DEPTH-1:0]	rdyb_q;
	alu_op_t				op_q [RS_DEPTH];
	imm_t					imm_q [RS_DEPTH];
	preg_idx_t				opa_q [RS_DEPTH];
	preg_idx_t				opb_q [RS_DEPTH];
	preg_idx_t				dest_q [RS_DEPTH];
	logic [ROB_W-1:0]		rob_q [RS_DEPTH];
	logic [RS_DEPTH-1:0]	ready_vec;	// both operands in
	logic [SEL_W-1:0]		iss_sel;
	logic [SEL_W-1:0]		free_sel;
	logic					opa_wake;
	logic					opb_wake;
	logic					iss_src_pending;	// issued tag still owed by a waiting producer

	assign ready_vec   = valid_q & rdya_q & rdyb_q;
	assign full_o      = &valid_q;
	assign iss_valid_o = |ready_vec;

	// lowest index wins for both issue and allocation
	always_comb begin
		iss_sel  = '0;
		free_sel = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (ready_vec[i]) iss_sel = SEL_W'(i);
			if (!valid_q[i]) free_sel = SEL_W'(i);
		end
	end

	assign iss_op_o      = op_q[iss_sel];
	assign iss_imm_o     = imm_q[iss_sel];
	assign iss_opa_o     = opa_q[iss_sel];	// prf read address
	assign iss_opb_o     = opb_q[iss_sel];
	assign iss_dest_o    = dest_q[iss_sel];
	assign iss_rob_idx_o = rob_q[iss_sel];

	// tag arriving on the cdb in the dispatch cycle
	assign opa_wake = cdb_valid_i && (cdb_tag_i == opa_preg_i);
	assign opb_wake = cdb_valid_i && (cdb_tag_i == opb_preg_i);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_q <= '0;
			rdya_q  <= '0;
			rdyb_q  <= '0;
		end else begin
			for (int i = 0; i < RS_DEPTH; i++) begin
				if (cdb_valid_i && opa_q[i] == cdb_tag_i) rdya_q[i] <= 1'b1;
				if (cdb_valid_i && opb_q[i] == cdb_tag_i) rdyb_q[i] <= 1'b1;
			end
			if (iss_valid_o) valid_q[iss_sel] <= 1'b0;	// leaves on issue
			if (dispatch_i) begin
				valid_q[free_sel] <= 1'b1;
				rdya_q[free_sel]  <= opa_rdy_i | opa_wake;
				rdyb_q[free_sel]  <= opb_rdy_i | opb_wake;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch_i) begin	// payload only
			op_q[free_sel]   <= op_i;
			imm_q[free_sel]  <= imm_i;
			opa_q[free_sel]  <= opa_preg_i;
			opb_q[free_sel]  <= opb_preg_i;
			dest_q[free_sel] <= dest_preg_i;
			rob_q[free_sel]  <= rob_idx_i;
		end
	end

	// a source still to be produced by a waiting entry is not ready yet
	always_comb begin
		iss_src_pending = 1'b0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (valid_q[i] && dest_q[i] != ZERO_PREG &&
				(dest_q[i] == iss_opa_o || dest_q[i] == iss_opb_o)) begin
				iss_src_pending = 1'b1;
			end
		end
	end

	// issued entry really has both operands
	a_issue_ready: assert property (@(posedge clk) disable iff (reset_i)
		iss_valid_o |-> !iss_src_pending);

endmodule: rs

//--- rob.sv
//========================================
// reorder buffer
//========================================
module rob #(
	parameter int ROB_DEPTH = 16
) (
	input  logic							clk,
	input  logic							reset_i,
	input  logic							dispatch_i,
	input  core_pkg::areg_idx_t				dest_areg_i,
	input  core_pkg::preg_idx_t				new_preg_i,		// tnew
	input  core_pkg::preg_idx_t				old_preg_i,		// told
	input  logic							done_i,
	input  logic [$clog2(ROB_DEPTH)-1:0]	done_idx_i,
	output logic [$clog2(ROB_DEPTH)-1:0]	tail_idx_o,
	output logic							full_o,
	output logic							retire_valid_o,
	output core_pkg::areg_idx_t				retire_dest_o,
	output core_pkg::preg_idx_t				retire_preg_o,	// prf port c
	output logic							free_push_o,
	output core_pkg::preg_idx_t				free_preg_o
);
	import core_pkg::*;

	localparam int IDX_W = $clog2(ROB_DEPTH);

	logic [IDX_W-1:0]		head_q;
	logic [IDX_W-1:0]		tail_q;
	logic [IDX_W:0]			count_q;
	logic [ROB_DEPTH-1:0]	done_q;
	areg_idx_t				dest_q [ROB_DEPTH];
	preg_idx_t				new_q [ROB_DEPTH];
	preg_idx_t				old_q [ROB_DEPTH];

	assign tail_idx_o     = tail_q;	// rob slot of the next dispatch
	assign full_o         = count_q == (IDX_W+1)'(ROB_DEPTH);
	assign retire_valid_o = (count_q != '0) && done_q[head_q];
	assign retire_dest_o  = dest_q[head_q];
	assign retire_preg_o  = new_q[head_q];
	assign free_preg_o    = old_q[head_q];
	// areg zero never took a preg, nothing to give back
	assign free_push_o    = retire_valid_o && (dest_q[head_q] != ZERO_AREG);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			done_q  <= '0;
		end else begin
			if (done_i) done_q[done_idx_i] <= 1'b1;	// alu writeback
			if (dispatch_i) begin
				done_q[tail_q] <= 1'b0;
				tail_q         <= tail_q + 1'b1;
			end
			if (retire_valid_o) head_q <= head_q + 1'b1;	// one per cycle
			case ({dispatch_i, retire_valid_o})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch_i) begin
			dest_q[tail_q] <= dest_areg_i;
			new_q[tail_q]  <= new_preg_i;
			old_q[tail_q]  <= old_preg_i;
		end
	end

	// top level stall must cover a full buffer
	a_no_dispatch_full: assert property (@(posedge clk) disable iff (reset_i)
		dispatch_i |-> !full_o);

endmodule: rob

//--- fu_alu.sv
//========================================
// two stage integer alu
//========================================
module fu_alu #(
	parameter int ROB_DEPTH = 16
) (
	input  logic							clk,
	input  logic							reset_i,
	input  logic							iss_valid_i,
	input  core_pkg::alu_op_t				iss_op_i,
	input  core_pkg::imm_t					iss_imm_i,
	input  core_pkg::word_t					opa_value_i,
	input  core_pkg::word_t					opb_value_i,
	input  core_pkg::preg_idx_t				iss_dest_i,
	input  logic [$clog2(ROB_DEPTH)-1:0]	iss_rob_idx_i,
	output logic							cdb_valid_o,	// also prf wr_en and done
	output core_pkg::preg_idx_t				cdb_tag_o,
	output core_pkg::word_t					cdb_value_o,
	output logic [$clog2(ROB_DEPTH)-1:0]	done_idx_o
);
	import core_pkg::*;

	localparam int ROB_W = $clog2(ROB_DEPTH);

	logic				s1_valid_q;
	alu_op_t			s1_op_q;
	imm_t				s1_imm_q;
	word_t				s1_a_q;
	word_t				s1_b_q;
	preg_idx_t			s1_dest_q;
	logic [ROB_W-1:0]	s1_rob_q;
	word_t				imm_ext;
	word_t				result;

	assign imm_ext = word_t'(s1_imm_q);	// zero extend

	always_comb begin
		case (s1_op_q)
			OP_SUB:  result = s1_a_q - s1_b_q;
			OP_AND:  result = s1_a_q & s1_b_q;
			OP_OR:   result = s1_a_q | s1_b_q;
			OP_XOR:  result = s1_a_q ^ s1_b_q;
			OP_ADDI: result = s1_a_q + imm_ext;
			OP_LUI:  result = imm_ext << LUI_SHIFT;
			default: result = s1_a_q + s1_b_q;	// OP_ADD and spare codes
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			s1_valid_q  <= 1'b0;
			cdb_valid_o <= 1'b0;
		end else begin
			s1_valid_q  <= iss_valid_i;	// stage 1, capture at issue
			cdb_valid_o <= s1_valid_q;	// stage 2, broadcast
		end
	end

	always_ff @(posedge clk) begin
		s1_op_q     <= iss_op_i;
		s1_imm_q    <= iss_imm_i;
		s1_a_q      <= opa_value_i;
		s1_b_q      <= opb_value_i;
		s1_dest_q   <= iss_dest_i;
		s1_rob_q    <= iss_rob_idx_i;
		cdb_tag_o   <= s1_dest_q;
		cdb_value_o <= result;
		done_idx_o  <= s1_rob_q;
	end

endmodule: fu_alu

//--- preg_file.sv
//========================================
// physical register file
//========================================
module preg_file (
	input  logic					clk,
	input  logic					reset_i,
	input  logic					wr_en_i,
	input  core_pkg::preg_idx_t		wr_idx_i,
	input  core_pkg::word_t			wr_data_i,
	input  core_pkg::preg_idx_t		rda_idx_i,	// issue opa
	input  core_pkg::preg_idx_t		rdb_idx_i,	// issue opb
	input  core_pkg::preg_idx_t		rdc_idx_i,	// retire value
	output core_pkg::word_t			rda_data_o,
	output core_pkg::word_t			rdb_data_o,
	output core_pkg::word_t			rdc_data_o
);
	import core_pkg::*;

	word_t regs_q [NUM_PREGS];

	assign rda_data_o = regs_q[rda_idx_i];
	assign rdb_data_o = regs_q[rdb_idx_i];
	assign rdc_data_o = regs_q[rdc_idx_i];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_PREGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_en_i && wr_idx_i != ZERO_PREG) begin
			regs_q[wr_idx_i] <= wr_data_i;	// preg 0 stays zero
		end
	end

endmodule: preg_file

//--- core.sv
//========================================
// rename core top level
//========================================
module core #(
	parameter int RS_DEPTH  = 8,
	parameter int ROB_DEPTH = 16
) (
	input  logic					clk,
	input  logic					reset_i,
	input  logic					instr_valid_i,
	input  core_pkg::instr_t		instr_i,
	output logic					instr_ready_o,
	output logic					retire_valid_o,
	output core_pkg::areg_idx_t		retire_dest_o,
	output core_pkg::word_t			retire_value_o
);
	import core_pkg::*;

	localparam int ROB_W = $clog2(ROB_DEPTH);

	// decode and dispatch
	alu_op_t			dec_op;
	areg_idx_t			dec_dest;
	areg_idx_t			dec_ra;
	areg_idx_t			dec_rb;
	imm_t				dec_imm;
	logic				needs_preg;		// dest is not areg zero
	logic				dispatch_block;
	logic				dispatch_en;
	logic				fl_pop;
	preg_idx_t			new_preg;

	// rename
	preg_idx_t			opa_preg;
	preg_idx_t			opb_preg;
	logic				opa_rdy;
	logic				opb_rdy;
	preg_idx_t			old_preg;
	logic				free_valid;
	preg_idx_t			free_preg;

	// rs issue
	logic				rs_full;
	logic				iss_valid;
	alu_op_t			iss_op;
	imm_t				iss_imm;
	preg_idx_t			iss_opa;
	preg_idx_t			iss_opb;
	preg_idx_t			iss_dest;
	logic [ROB_W-1:0]	iss_rob_idx;
	word_t				opa_value;
	word_t				opb_value;

	// rob and cdb
	logic [ROB_W-1:0]	rob_tail;
	logic				rob_full;
	preg_idx_t			retire_preg;
	logic				free_push;
	preg_idx_t			free_push_preg;
	logic				cdb_valid;
	preg_idx_t			cdb_tag;
	word_t				cdb_value;
	logic [ROB_W-1:0]	done_idx;

	//========================================
	// decode and dispatch control
	//========================================
	assign dec_op   = instr_i[31:29];
	assign dec_dest = instr_i[28:24];
	assign dec_ra   = instr_i[23:19];
	assign dec_rb   = instr_i[18:14];
	assign dec_imm  = instr_i[13:0];

	assign needs_preg     = dec_dest != ZERO_AREG;
	assign dispatch_block = rs_full | rob_full | (needs_preg & ~free_valid);
	assign instr_ready_o  = ~dispatch_block;	// never looks at valid
	assign dispatch_en    = instr_valid_i & instr_ready_o;
	assign fl_pop         = dispatch_en & needs_preg;
	// zero dest writes preg 0, so its broadcast wakes nobody
	assign new_preg       = needs_preg ? free_preg : ZERO_PREG;

	//========================================
	// instances
	//========================================
	map_table map_table0 (
		.clk			(clk),
		.reset_i		(reset_i),
		.ra_i			(dec_ra),
		.rb_i			(dec_rb),
		.dest_i			(dec_dest),
		.rename_en_i	(fl_pop),
		.new_preg_i		(free_preg),
		.cdb_valid_i	(cdb_valid),
		.cdb_tag_i		(cdb_tag),
		.opa_preg_o		(opa_preg),
		.opb_preg_o		(opb_preg),
		.opa_rdy_o		(opa_rdy),
		.opb_rdy_o		(opb_rdy),
		.old_preg_o		(old_preg)	// told for the rob
	);

	free_list free_list0 (
		.clk			(clk),
		.reset_i		(reset_i),
		.pop_i			(fl_pop),
		.push_i			(free_push),
		.push_preg_i	(free_push_preg),
		.free_valid_o	(free_valid),
		.free_preg_o	(free_preg)
	);

	rs #(
		.RS_DEPTH		(RS_DEPTH),
		.ROB_DEPTH		(ROB_DEPTH)
	) rs0 (
		.clk			(clk),
		.reset_i		(reset_i),
		.dispatch_i		(dispatch_en),
		.op_i			(dec_op),
		.imm_i			(dec_imm),
		.opa_preg_i		(opa_preg),
		.opb_preg_i		(opb_preg),
		.opa_rdy_i		(opa_rdy),
		.opb_rdy_i		(opb_rdy),
		.dest_preg_i	(new_preg),
		.rob_idx_i		(rob_tail),
		.cdb_valid_i	(cdb_valid),
		.cdb_tag_i		(cdb_tag),
		.full_o			(rs_full),
		.iss_valid_o	(iss_valid),
		.iss_op_o		(iss_op),
		.iss_imm_o		(iss_imm),
		.iss_opa_o		(iss_opa),
		.iss_opb_o		(iss_opb),
		.iss_dest_o		(iss_dest),
		.iss_rob_idx_o	(iss_rob_idx)
	);

	rob #(
		.ROB_DEPTH		(ROB_DEPTH)
	) rob0 (
		.clk			(clk),
		.reset_i		(reset_i),
		.dispatch_i		(dispatch_en),
		.dest_areg_i	(dec_dest),
		.new_preg_i		(new_preg),
		.old_preg_i		(old_preg),
		.done_i			(cdb_valid),
		.done_idx_i		(done_idx),
		.tail_idx_o		(rob_tail),
		.full_o			(rob_full),
		.retire_valid_o	(retire_valid_o),
		.retire_dest_o	(retire_dest_o),
		.retire_preg_o	(retire_preg),
		.free_push_o	(free_push),
		.free_preg_o	(free_push_preg)
	);

	fu_alu #(
		.ROB_DEPTH		(ROB_DEPTH)
	) fu_alu0 (
		.clk			(clk),
		.reset_i		(reset_i),
		.iss_valid_i	(iss_valid),
		.iss_op_i		(iss_op),
		.iss_imm_i		(iss_imm),
		.opa_value_i	(opa_value),
		.opb_value_i	(opb_value),
		.iss_dest_i		(iss_dest),
		.iss_rob_idx_i	(iss_rob_idx),
		.cdb_valid_o	(cdb_valid),
		.cdb_tag_o		(cdb_tag),
		.cdb_value_o	(cdb_value),
		.done_idx_o		(done_idx)
	);

	preg_file preg_file0 (
		.clk			(clk),
		.reset_i		(reset_i),
		.wr_en_i		(cdb_valid),	// writeback rides the cdb
		.wr_idx_i		(cdb_tag),
		.wr_data_i		(cdb_value),
		.rda_idx_i		(iss_opa),
		.rdb_idx_i		(iss_opb),
		.rdc_idx_i		(retire_preg),
		.rda_data_o		(opa_value),
		.rdb_data_o		(opb_value),
		.rdc_data_o		(retire_value_o)
	);

endmodule: core

//--- core_tb.sv
//========================================
// rename core testbench
//========================================
module core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import core_pkg::*;

	localparam int RS_DEPTH         = 8;
	localparam int ROB_DEPTH        = 16;
	localparam int RESET_CYCLES     = 10;
	localparam int PASSES           = 3;	// last pass repeats each word back to back
	localparam int BURST            = 8;	// copies per word in the last pass
	localparam int CYCLES_PER_INSTR = 40;	// watchdog budget

	logic		clk;
	logic		reset_i;
	logic		instr_valid_i;
	instr_t		instr_i;
	logic		instr_ready_o;
	logic		retire_valid_o;
	areg_idx_t	retire_dest_o;
	word_t		retire_value_o;

	logic [31:0]	prog_word [$];		// from program_input.txt
	logic [31:0]	prog_gap [$];		// idle cycles, ff is random
	logic [4:0]		exp_dest_q [$];		// reference model, program order
	logic [63:0]	exp_value_q [$];
	logic [63:0]	arch_regs [32];		// architectural state of the model
	int				seed          = 32'h897b_952c;
	int				error_cnt     = 0;
	int				retire_cnt    = 0;
	int				sent_cnt      = 0;
	int				stall_cnt     = 0;	// cycles held by back-pressure
	int				test_cnt      = 0;
	int				test_fail_cnt = 0;
	int				prog_len      = 0;
	int				total_cnt     = 0;	// instructions over all passes

	core #(
		.RS_DEPTH		(RS_DEPTH),
		.ROB_DEPTH		(ROB_DEPTH)
	) dut0 (
		.clk			(clk),
		.reset_i		(reset_i),
		.instr_valid_i	(instr_valid_i),
		.instr_i		(instr_i),
		.instr_ready_o	(instr_ready_o),
		.retire_valid_o	(retire_valid_o),
		.retire_dest_o	(retire_dest_o),
		.retire_value_o	(retire_value_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	//========================================
	// reference model
	//========================================
	function automatic logic [63:0] alu_ref(input logic [2:0] op, input logic [63:0] a,
		input logic [63:0] b, input logic [13:0] imm);
		logic [63:0] ext;
		ext = {50'b0, imm};	// zero extend
		case (op)
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_ADDI: return a + ext;
			OP_LUI:  return ext << 16;
			default: return a + b;	// add and the spare code
		endcase
	endfunction

	task automatic model_instr(input logic [31:0] word);
		logic [4:0]		dest;
		logic [63:0]	res;
		dest = word[28:24];
		res  = alu_ref(word[31:29], arch_regs[word[23:19]], arch_regs[word[18:14]],
			word[13:0]);
		if (dest != 5'd0) arch_regs[dest] = res;
		else res = '0;	// r0 keeps zero
		exp_dest_q.push_back(dest);
		exp_value_q.push_back(res);
	endtask

	task automatic load_program();
		int				fd;
		int				code;
		string			line;
		logic [31:0]	word;
		logic [31:0]	gap;
		fd = $fopen("program_input.txt", "r");
		assert (fd != 0) else begin
			$display("Cannot open program_input.txt");
			error_cnt++;
		end
		if (fd != 0) begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && $sscanf(line, "%h %h", word, gap) == 2) begin	// skips comments
					prog_word.push_back(word);
					prog_gap.push_back(gap);
				end
			end
			$fclose(fd);
		end
		prog_len  = prog_word.size();
		total_cnt = prog_len * (PASSES - 1 + BURST);
		assert (prog_len > 0) else begin
			$display("program_input.txt holds no instructions");
			error_cnt++;
		end
	endtask

	//========================================
	// drive and check
	//========================================
	task automatic send_instr(input logic [31:0] word, input int gap);
		repeat (gap) @(negedge clk);
		model_instr(word);
		instr_i       = word;
		instr_valid_i = 1'b1;
		#1;	// ready follows the dest field
		while (instr_ready_o !== 1'b1) begin	// hold under back-pressure
			stall_cnt++;
			@(negedge clk);
			#1;
		end
		@(negedge clk);	// transfer edge passed
		instr_valid_i = 1'b0;
		sent_cnt++;
	endtask

	task automatic run_pass(input int pass);
		int gap;
		int copies;
		copies = (pass == PASSES - 1) ? BURST : 1;	// copies chain on themselves
		for (int i = 0; i < prog_len; i++) begin
			if (pass == PASSES - 1) gap = 0;
			else if (prog_gap[i] == 32'hff) gap = $unsigned($random(seed)) % 4;
			else gap = prog_gap[i];
			repeat (copies) send_instr(prog_word[i], gap);
		end
		wait (retire_cnt == sent_cnt);	// pass drained
	endtask

	task automatic check_idle();
		assert (retire_valid_o === 1'b0) else begin
			$display("Mismatch retire_valid_o: got %h, expected %h", retire_valid_o, 1'b0);
			error_cnt++;
		end
		assert (instr_ready_o === 1'b1) else begin
			$display("Mismatch instr_ready_o: got %h, expected %h", instr_ready_o, 1'b1);
			error_cnt++;
		end
	endtask

	task automatic check_retire();
		logic [4:0]		exp_dest;
		logic [63:0]	exp_value;
		retire_cnt++;
		assert (exp_dest_q.size() != 0) else begin
			$display("Retire %0d arrived with no instruction outstanding", retire_cnt);
			error_cnt++;
		end
		if (exp_dest_q.size() != 0) begin
			exp_dest  = exp_dest_q.pop_front();
			exp_value = exp_value_q.pop_front();
			assert (retire_dest_o === exp_dest) else begin
				$display("Mismatch retire_dest_o at retire %0d: got %h, expected %h",
					retire_cnt, retire_dest_o, exp_dest);
				error_cnt++;
			end
			assert (retire_value_o === exp_value) else begin
				$display("Mismatch retire_value_o at retire %0d: got %h, expected %h",
					retire_cnt, retire_value_o, exp_value);
				error_cnt++;
			end
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		int errs;
		errs = error_cnt - errs_before;
		test_cnt++;
		if (errs == 0) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			test_fail_cnt++;
			$display("test %0d %s: FAILED with %0d errors", test_cnt, name, errs);
		end
	endtask

	// retire port sampled mid cycle, stable there
	initial begin
		forever begin
			@(negedge clk);
			if (reset_i === 1'b0 && retire_valid_o === 1'b1) check_retire();
		end
	end

	initial begin
		wait (total_cnt > 0);
		repeat (total_cnt * CYCLES_PER_INSTR + RESET_CYCLES) @(posedge clk);
		$display("Timeout: core hung with %0d of %0d instructions retired",
			retire_cnt, total_cnt);
		$display("Some tests failed");
		$finish;
	end

	//========================================
	// main sequence
	//========================================
	initial begin
		int errs_before;
		reset_i       = 1'b1;
		instr_valid_i = 1'b0;
		instr_i       = '0;
		for (int i = 0; i < 32; i++) begin
			arch_regs[i] = '0;	// matches reset mapping
		end
		load_program();

		errs_before = error_cnt;
		@(posedge clk);	// first reset edge
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_idle();
		end
		reset_i = 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_idle();
		end
		report_test("reset state", errs_before);

		for (int p = 0; p < PASSES; p++) begin
			errs_before = error_cnt;
			stall_cnt   = 0;
			run_pass(p);
			if (p == PASSES - 1) begin
				assert (stall_cnt > 0) else begin
					$display("Burst pass never saw instr_ready_o go low");
					error_cnt++;
				end
				report_test("burst pass", errs_before);
			end else begin
				report_test($sformatf("program pass %0d", p + 1), errs_before);
			end
		end

		errs_before = error_cnt;
		repeat (8) begin	// nothing extra may retire
			@(negedge clk);
			check_idle();
		end
		assert (retire_cnt == total_cnt) else begin
			$display("Mismatch retire count: got %h, expected %h", retire_cnt, total_cnt);
			error_cnt++;
		end
		report_test("drain", errs_before);

		$display("%0d tests, %0d failed, %0d retires, %0d errors", test_cnt, test_fail_cnt,
			retire_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule: core_tb

//--- program_input.txt
// columns: instruction word (op|dest|ra|rb|imm), idle cycles before it in hex
// a gap of FF draws a random gap of 0..3
A1000123 00  // addi r1
C2001234 01  // lui r2
A3000F0F 00  // addi r3
04088000 02  // add r4 = r1 + r2
25104000 00  // sub r5 = r2 - r1
46190000 FF  // and r6 = r3 & r4
67184000 00  // or r7 = r3 | r1
8820C000 FF  // xor r8 = r4 ^ r3
E908C000 00  // spare opcode, acts as add
AA500001 00  // chain on r10
AA500002 00
0A528000 00  // add r10 = r10 + r10
2B504000 00  // sub r11 = r10 - r1
A0080055 00  // write to r0 retires zero
0C014000 FF  // add r12 = r0 + r5
C0003FFF 03  // lui r0
AD680010 00  // repeated writes to r13
8D688000 00
AD683FFF FF
6E6AC000 00  // or r14 = r13 | r11
0F728000 00  // add r15 = r14 + r10
3F7B4000 00  // sub r31 = r15 - r13

//--- project.f
core_pkg.sv
map_table.sv
free_list.sv
rs.sv
rob.sv
fu_alu.sv
preg_file.sv
core.sv
core_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = core_tb
FILELIST = project.f
OBJDIR   = obj_dir
PASS_MSG = All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
